// ==== common/hyper_pkg.sv ====
// Shared widths for staged words, DRAM columns, addresses, sections and counts, and size limits.
`default_nettype none

package hyper_pkg;

	// One staged data word.
	localparam int WORD_W = 16;

	// A DRAM column holds two staged words, low word at the even address.
	localparam int COL_W = 2 * WORD_W;

	// Word address into the column store.
	localparam int ADDR_W = 12;

	// Section index of the staging buffer, four sections.
	localparam int SECT_W = 2;

	// Block length and count_left.
	localparam int CNT_W = 5;

	// Longest block the mover accepts.
	localparam int BLOCK_MAX = 24;

	// Words per buffer section unless the top level says otherwise.
	localparam int DEPTH_DEFAULT = 32;

endpackage : hyper_pkg

`default_nettype wire

// ==== hdl/lsab_fill.sv ====
// Fill stage: registered routing of tagged input words into the staging buffer sections.
`timescale 1ns/100ps
`default_nettype none

module lsab_fill
#(
	parameter int SECT_DEPTH = hyper_pkg::DEPTH_DEFAULT
)
(
	input  wire                          CLK,
	input  wire                          RST,
	input  wire                          in_strobe,
	input  wire  [hyper_pkg::SECT_W-1:0] in_section,
	input  wire  [hyper_pkg::WORD_W-1:0] in_word,
	input  wire                          rd_strobe,   // Pops issued to the buffer.
	input  wire  [hyper_pkg::SECT_W-1:0] rd_section,
	output logic                         wr_strobe,
	output logic [hyper_pkg::SECT_W-1:0] wr_section,
	output logic [hyper_pkg::WORD_W-1:0] wr_word
);
	import hyper_pkg::*;

	localparam int NUM_SECT = 2 ** SECT_W;
	localparam int OCC_W = $clog2(SECT_DEPTH + 1);

	logic [OCC_W-1:0] occupancy [NUM_SECT];   // Words held per section.

	always_ff @(posedge CLK)
	begin
		if (!RST)
			wr_strobe <= 1'b0;
		else
			wr_strobe <= in_strobe;
		wr_section <= in_section;   // Payload follows the strobe.
		wr_word <= in_word;
	end

	// Mirror of the buffer fill level, one counter per section.
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int s = 0; s < NUM_SECT; s++)
				occupancy[s] <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_SECT; s++)
			begin
				if ((wr_strobe && wr_section == s) && !(rd_strobe && rd_section == s))
					occupancy[s] <= occupancy[s] + 1'b1;
				else if (!(wr_strobe && wr_section == s) && (rd_strobe && rd_section == s))
					occupancy[s] <= occupancy[s] - 1'b1;
			end
		end
	end

	// The input side has no back-pressure, so a full section is a stimulus error.
	assert property (@(posedge CLK) disable iff (!RST)
		wr_strobe |-> (occupancy[wr_section] < SECT_DEPTH));

endmodule : lsab_fill

`default_nettype wire

// ==== lsab/lsab_buffer.sv ====
// Staging buffer with four circular sections in one memory, empty flags and a registered read port.
`timescale 1ns/100ps
`default_nettype none

module lsab_buffer
#(
	parameter int SECT_DEPTH = hyper_pkg::DEPTH_DEFAULT   // Power of two.
)
(
	input  wire                          CLK,
	input  wire                          RST,
	input  wire                          wr_strobe,
	input  wire  [hyper_pkg::SECT_W-1:0] wr_section,
	input  wire  [hyper_pkg::WORD_W-1:0] wr_word,
	input  wire                          rd_strobe,
	input  wire  [hyper_pkg::SECT_W-1:0] rd_section,
	output logic [hyper_pkg::WORD_W-1:0] rd_word,
	output logic                         empty_0,
	output logic                         empty_1,
	output logic                         empty_2,
	output logic                         empty_3
);
	import hyper_pkg::*;

	localparam int NUM_SECT = 2 ** SECT_W;
	localparam int PTR_W = $clog2(SECT_DEPTH);

	logic [WORD_W-1:0] mem [NUM_SECT * SECT_DEPTH];

	// Pointer MSB is the wrap bit.
	logic [PTR_W:0] head [NUM_SECT];
	logic [PTR_W:0] tail [NUM_SECT];

	logic [NUM_SECT-1:0] empty_v;
	logic [NUM_SECT-1:0] full_v;

	always_comb
	begin
		for (int s = 0; s < NUM_SECT; s++)
		begin
			empty_v[s] = (head[s] == tail[s]);
			full_v[s] = (head[s][PTR_W-1:0] == tail[s][PTR_W-1:0]) &&
				(head[s][PTR_W] != tail[s][PTR_W]);
		end
	end

	assign empty_0 = empty_v[0];
	assign empty_1 = empty_v[1];
	assign empty_2 = empty_v[2];
	assign empty_3 = empty_v[3];

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			for (int s = 0; s < NUM_SECT; s++)
			begin
				head[s] <= '0;
				tail[s] <= '0;
			end
		end
		else
		begin
			// Read and write pointers move independently, also within one section.
			if (wr_strobe)
				tail[wr_section] <= tail[wr_section] + 1'b1;
			if (rd_strobe)
				head[rd_section] <= head[rd_section] + 1'b1;
		end
	end

	// Section index selects the region, pointer selects the slot.
	always_ff @(posedge CLK)
	begin
		if (wr_strobe)
			mem[{wr_section, tail[wr_section][PTR_W-1:0]}] <= wr_word;
		if (rd_strobe)
			rd_word <= mem[{rd_section, head[rd_section][PTR_W-1:0]}];   // Held until next pop.
	end

	assert property (@(posedge CLK) disable iff (!RST)
		rd_strobe |-> !empty_v[rd_section]);

	assert property (@(posedge CLK) disable iff (!RST)
		wr_strobe |-> !full_v[wr_section]);

endmodule : lsab_buffer

`default_nettype wire

// ==== mover/hyper_mvblck_todram.sv ====
// Block mover: drains one buffer section into byte-masked DRAM column writes.
`timescale 1ns/100ps
`default_nettype none

module hyper_mvblck_todram
(
	input  wire                          CLK,
	input  wire                          RST,
	input  wire                          empty_0,
	input  wire                          empty_1,
	input  wire                          empty_2,
	input  wire                          empty_3,
	output logic                         rd_strobe,
	output logic [hyper_pkg::SECT_W-1:0] rd_section,
	input  wire  [hyper_pkg::WORD_W-1:0] rd_word,
	input  wire  [hyper_pkg::ADDR_W-1:0] start_address,
	input  wire  [hyper_pkg::CNT_W-1:0]  count,
	input  wire  [hyper_pkg::SECT_W-1:0] section,
	input  wire                          issue,
	output logic [hyper_pkg::CNT_W-1:0]  count_left,
	output logic                         working,
	output logic [hyper_pkg::ADDR_W-2:0] col_address,
	output logic [3:0]                   col_we,
	output logic [hyper_pkg::COL_W-1:0]  col_data,
	output logic                         col_request
);
	import hyper_pkg::*;

	logic              busy;         // Block in progress.
	logic              idle;
	logic              sel_empty;
	logic [CNT_W-1:0]  words_left;   // Words still to pop.
	logic [ADDR_W-1:0] track_addr;   // Address of the next word to pop.
	logic              word_valid;   // rd_word holds a fresh word.
	logic [ADDR_W-1:0] word_addr;
	logic              col_done;
	logic [WORD_W-1:0] low_word;
	logic              low_valid;
	logic              pre_request;
	logic [ADDR_W-2:0] pre_address;
	logic [3:0]        pre_we;
	logic [COL_W-1:0]  pre_data;

	always_comb
	begin
		case (rd_section)
			2'd0: sel_empty = empty_0;
			2'd1: sel_empty = empty_1;
			2'd2: sel_empty = empty_2;
			2'd3: sel_empty = empty_3;
			default: sel_empty = 1'b1;
		endcase
	end

	// Commands wait until the previous block has fully drained out.
	assign idle = !busy && !working;
	assign rd_strobe = busy && !sel_empty && (words_left != '0);

	// High half closes a column, and so does the last word of the block.
	assign col_done = word_valid && (word_addr[0] || !rd_strobe);

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			busy <= 1'b0;
			working <= 1'b0;
			count_left <= '0;
			rd_section <= '0;
			words_left <= '0;
			track_addr <= '0;
			word_valid <= 1'b0;
			low_valid <= 1'b0;
			pre_request <= 1'b0;
			col_request <= 1'b0;
			col_we <= 4'b0000;
		end
		else
		begin
			if (idle && issue)
			begin
				busy <= 1'b1;
				rd_section <= section;
				words_left <= count;
				track_addr <= start_address;
			end
			else if (rd_strobe)
			begin
				words_left <= words_left - 1'b1;
				track_addr <= track_addr + 1'b1;
			end
			else if (busy)
			begin
				busy <= 1'b0;   // Count reached or section ran dry.
				count_left <= words_left;
			end
			word_valid <= rd_strobe;
			if (col_done)
				low_valid <= 1'b0;
			else if (word_valid)
				low_valid <= 1'b1;
			pre_request <= col_done;
			// One extra cycle so the data can clear the switch.
			col_request <= pre_request;
			col_we <= pre_request ? pre_we : 4'b0000;
			working <= busy;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rd_strobe)
			word_addr <= track_addr;
		if (word_valid && !word_addr[0])
			low_word <= rd_word;
		if (col_done)
		begin
			pre_address <= word_addr[ADDR_W-1:1];
			if (word_addr[0])
			begin
				pre_data <= {rd_word, low_word};
				pre_we <= {2'b11, low_valid, low_valid};
			end
			else
			begin
				pre_data <= {{WORD_W{1'b0}}, rd_word};
				pre_we <= 4'b0011;   // Block ends on an even word.
			end
		end
		col_address <= pre_address;
		col_data <= pre_data;
	end

	assert property (@(posedge CLK) disable iff (!RST)
		(idle && issue) |-> (count <= BLOCK_MAX));

	assert property (@(posedge CLK) disable iff (!RST)
		col_request |-> (col_we != 4'b0000));

endmodule : hyper_mvblck_todram

`default_nettype wire

// ==== hdl/dram_column_store.sv ====
// Column store: byte-masked 32-bit column memory with a registered, write-through read port.
`timescale 1ns/100ps
`default_nettype none

module dram_column_store
#(
	parameter int COL_COUNT = 2048
)
(
	input  wire                          CLK,
	input  wire                          col_request,
	input  wire  [hyper_pkg::ADDR_W-2:0] col_address,
	input  wire  [3:0]                   col_we,
	input  wire  [hyper_pkg::COL_W-1:0]  col_data,
	input  wire  [hyper_pkg::ADDR_W-2:0] rd_address,
	output logic [hyper_pkg::COL_W-1:0]  rd_column
);
	import hyper_pkg::*;

	localparam int LANE_W = COL_W / 4;   // One byte lane.

	logic [COL_W-1:0] mem [COL_COUNT];
	logic [COL_W-1:0] rd_merge;

	// A write to the column being read shows up on the same edge.
	always_comb
	begin
		rd_merge = mem[rd_address];
		if (col_request && (col_address == rd_address))
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (col_we[b])
					rd_merge[b*LANE_W +: LANE_W] = col_data[b*LANE_W +: LANE_W];
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (col_request)
		begin
			for (int b = 0; b < 4; b++)
			begin
				if (col_we[b])
					mem[col_address][b*LANE_W +: LANE_W] <= col_data[b*LANE_W +: LANE_W];
			end
		end
		rd_column <= rd_merge;
	end

	// Smaller stores do not cover the whole address range.
	assert property (@(posedge CLK)
		col_request |-> (col_address < COL_COUNT));

endmodule : dram_column_store

`default_nettype wire

// ==== hdl/hyper_block_top.sv ====
// Top level: fill stage, sectioned staging buffer, block mover and DRAM column store.
`timescale 1ns/100ps
`default_nettype none

module hyper_block_top
#(
	parameter int SECT_DEPTH = hyper_pkg::DEPTH_DEFAULT,
	parameter int COL_COUNT = 2048
)
(
	input  wire                          CLK,
	input  wire                          RST,
	input  wire                          in_strobe,
	input  wire  [hyper_pkg::SECT_W-1:0] in_section,
	input  wire  [hyper_pkg::WORD_W-1:0] in_word,
	input  wire                          issue,
	input  wire  [hyper_pkg::ADDR_W-1:0] start_address,
	input  wire  [hyper_pkg::CNT_W-1:0]  count,
	input  wire  [hyper_pkg::SECT_W-1:0] section,
	output logic                         working,
	output logic [hyper_pkg::CNT_W-1:0]  count_left,
	input  wire  [hyper_pkg::ADDR_W-2:0] rd_address,
	output logic [hyper_pkg::COL_W-1:0]  rd_column
);
	import hyper_pkg::*;

	logic              wr_strobe;
	logic [SECT_W-1:0] wr_section;
	logic [WORD_W-1:0] wr_word;
	logic              rd_strobe;
	logic [SECT_W-1:0] rd_section;
	logic [WORD_W-1:0] rd_word;
	logic              empty_0;
	logic              empty_1;
	logic              empty_2;
	logic              empty_3;
	logic              col_request;
	logic [ADDR_W-2:0] col_address;
	logic [3:0]        col_we;
	logic [COL_W-1:0]  col_data;

	lsab_fill #(.SECT_DEPTH(SECT_DEPTH)) lsab_fill_inst
	(
		.CLK(CLK), .RST(RST),
		.in_strobe(in_strobe), .in_section(in_section), .in_word(in_word),
		.rd_strobe(rd_strobe), .rd_section(rd_section),
		.wr_strobe(wr_strobe), .wr_section(wr_section), .wr_word(wr_word)
	);

	lsab_buffer #(.SECT_DEPTH(SECT_DEPTH)) lsab_buffer_inst
	(
		.CLK(CLK), .RST(RST),
		.wr_strobe(wr_strobe), .wr_section(wr_section), .wr_word(wr_word),
		.rd_strobe(rd_strobe), .rd_section(rd_section), .rd_word(rd_word),
		.empty_0(empty_0), .empty_1(empty_1), .empty_2(empty_2), .empty_3(empty_3)
	);

	hyper_mvblck_todram hyper_mvblck_todram_inst
	(
		.CLK(CLK), .RST(RST),
		.empty_0(empty_0), .empty_1(empty_1), .empty_2(empty_2), .empty_3(empty_3),
		.rd_strobe(rd_strobe), .rd_section(rd_section), .rd_word(rd_word),
		.start_address(start_address), .count(count), .section(section), .issue(issue),
		.count_left(count_left), .working(working),
		.col_address(col_address), .col_we(col_we), .col_data(col_data),
		.col_request(col_request)
	);

	dram_column_store #(.COL_COUNT(COL_COUNT)) dram_column_store_inst
	(
		.CLK(CLK),
		.col_request(col_request), .col_address(col_address),
		.col_we(col_we), .col_data(col_data),
		.rd_address(rd_address), .rd_column(rd_column)
	);

endmodule : hyper_block_top

`default_nettype wire

// ==== tb/tb_hyper_block.sv ====
// Testbench for hyper_block_top that plays the command file and checks count_left and DRAM words.
`timescale 1ns/100ps
`default_nettype none

module tb_hyper_block;
	import hyper_pkg::*;

	logic              CLK;
	logic              RST;
	logic              in_strobe;
	logic [SECT_W-1:0] in_section;
	logic [WORD_W-1:0] in_word;
	logic              issue;
	logic [ADDR_W-1:0] start_address;
	logic [CNT_W-1:0]  count;
	logic [SECT_W-1:0] section;
	logic              working;
	logic [CNT_W-1:0]  count_left;
	logic [ADDR_W-2:0] rd_address;
	logic [COL_W-1:0]  rd_column;

	string             lines [$];   // Command lines without comments.
	string             cmd;
	int                fields;
	int                arg_a;
	int                arg_b;
	int                arg_c;
	int                errors = 0;
	int                checks = 0;
	int                cycles = 0;
	int                cycle_limit = 1000;
	logic              stray_pending;   // Issue to pulse while the next block runs.
	logic [SECT_W-1:0] stray_section;
	logic [ADDR_W-1:0] stray_address;
	logic [CNT_W-1:0]  stray_count;

	hyper_block_top #(.SECT_DEPTH(DEPTH_DEFAULT), .COL_COUNT(2048)) hyper_block_top_inst
	(
		.CLK(CLK), .RST(RST),
		.in_strobe(in_strobe), .in_section(in_section), .in_word(in_word),
		.issue(issue), .start_address(start_address), .count(count), .section(section),
		.working(working), .count_left(count_left),
		.rd_address(rd_address), .rd_column(rd_column)
	);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;   // 10 ns period.

	always @(posedge CLK)
	begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("Timeout: the run did not end within %0d clock cycles.", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic load_commands();
		int    fd;
		string line;
		fd = $fopen("tb/block_input.txt", "r");
		if (fd == 0)
		begin
			$display("The command file tb/block_input.txt could not be opened.");
			errors++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() > 1 && line[0] != "#")
				lines.push_back(line);
		end
		$fclose(fd);
		cycle_limit = 40 * lines.size() + 100;   // 40 cycles per command.
	endtask

	task automatic fill_words(input logic [SECT_W-1:0] sect, input logic [WORD_W-1:0] word,
		input int n);
		for (int i = 0; i < n; i++)
		begin
			@(posedge CLK);
			in_strobe <= 1'b1;
			in_section <= sect;
			in_word <= word + i[WORD_W-1:0];   // Consecutive values.
		end
		@(posedge CLK);
		in_strobe <= 1'b0;
	endtask

	task automatic wait_working(input logic level);
		@(negedge CLK);
		while (working !== level)
			@(negedge CLK);
	endtask

	task automatic run_block(input logic [SECT_W-1:0] sect, input logic [ADDR_W-1:0] addr,
		input logic [CNT_W-1:0] cnt);
		@(posedge CLK);
		issue <= 1'b1;
		section <= sect;
		start_address <= addr;
		count <= cnt;
		@(posedge CLK);
		issue <= 1'b0;
		wait_working(1'b1);
		if (stray_pending)
		begin
			@(posedge CLK);   // Mover is busy here.
			issue <= 1'b1;
			section <= stray_section;
			start_address <= stray_address;
			count <= stray_count;
			@(posedge CLK);
			issue <= 1'b0;
			stray_pending = 1'b0;
		end
		wait_working(1'b0);
	endtask

	task automatic check_count(input logic [CNT_W-1:0] expected);
		@(negedge CLK);
		checks++;
		assert (count_left === expected)
		else
		begin
			$display("Error: count_left expected %h, got %h", expected, count_left);
			errors++;
		end
	endtask

	// Even addresses sit in the low half of a column.
	task automatic check_words(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] value,
		input int n);
		logic [ADDR_W-1:0] a;
		logic [WORD_W-1:0] expected;
		logic [WORD_W-1:0] got;
		for (int i = 0; i < n; i++)
		begin
			a = addr + i[ADDR_W-1:0];
			expected = value + i[WORD_W-1:0];
			@(posedge CLK);
			rd_address <= a[ADDR_W-1:1];
			@(posedge CLK);
			@(negedge CLK);
			got = a[0] ? rd_column[COL_W-1:WORD_W] : rd_column[WORD_W-1:0];
			checks++;
			assert (got === expected)
			else
			begin
				$display("Error: rd_column word at %h expected %h, got %h", a, expected, got);
				errors++;
			end
		end
	endtask

	initial
	begin
		RST = 1'b0;
		in_strobe = 1'b0;
		in_section = '0;
		in_word = '0;
		issue = 1'b0;
		start_address = '0;
		count = '0;
		section = '0;
		rd_address = '0;
		stray_pending = 1'b0;
		stray_section = '0;
		stray_address = '0;
		stray_count = '0;
		load_commands();
		repeat (4) @(posedge CLK);
		RST <= 1'b1;
		@(negedge CLK);
		checks += 2;
		assert (working === 1'b0)
		else
		begin
			$display("Error: working after reset expected %h, got %h", 1'b0, working);
			errors++;
		end
		assert (count_left === '0)
		else
		begin
			$display("Error: count_left after reset expected %h, got %h", 5'h00, count_left);
			errors++;
		end
		foreach (lines[i])
		begin
			fields = $sscanf(lines[i], "%s %h %h %h", cmd, arg_a, arg_b, arg_c);
			if (cmd == "F")
				fill_words(arg_a[SECT_W-1:0], arg_b[WORD_W-1:0], (fields == 4) ? arg_c : 1);
			else if (cmd == "I")
				run_block(arg_a[SECT_W-1:0], arg_b[ADDR_W-1:0], arg_c[CNT_W-1:0]);
			else if (cmd == "S")
			begin
				stray_pending = 1'b1;
				stray_section = arg_a[SECT_W-1:0];
				stray_address = arg_b[ADDR_W-1:0];
				stray_count = arg_c[CNT_W-1:0];
			end
			else if (cmd == "W")
				check_words(arg_a[ADDR_W-1:0], arg_b[WORD_W-1:0], (fields == 4) ? arg_c : 1);
			else if (cmd == "C")
				check_count(arg_a[CNT_W-1:0]);
			else
			begin
				$display("The command line '%s' is not understood.", lines[i]);
				errors++;
			end
		end
		repeat (2) @(posedge CLK);
		$display("Run finished with %0d checks and %0d errors.", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule : tb_hyper_block

`default_nettype wire

// ==== tb/block_input.txt ====
# Commands for tb_hyper_block, all fields hex; optional n repeats with the value counting up.
# F sect word [n] fill | I sect addr count issue | S sect addr count issue while busy
# W addr value [n] expect DRAM word | C count expect count_left
# Full 24-word block from an even address.
F 0 a000 18
I 0 000 18
C 00
W 000 a000 18
# Empty section, nothing moves and the words stay.
I 0 004 06
C 06
W 004 a004 6
# Preload 100..107, then odd start and odd count over it.
F 1 b100 8
I 1 100 08
C 00
F 1 c101 5
I 1 101 05
C 00
W 100 b100
W 101 c101 5
W 106 b106 2
# Short section ends early, the next block continues in order.
F 3 f200 5
I 3 200 08
C 03
F 3 f205 3
I 3 205 03
C 00
W 200 f200 8
# Interleaved fills to all four sections.
F 0 1000
F 1 2000
F 2 3000
F 3 4000
F 0 1001
F 1 2001
F 2 3001
F 3 4001
I 2 300 02
C 00
W 300 3000 2
I 0 310 02
C 00
W 310 1000 2
I 3 320 03
C 01
W 320 4000 2
I 1 330 02
C 00
W 330 2000 2
# Issue during a block is dropped, section 1 keeps its words.
F 0 5400 4
I 0 400 04
C 00
F 0 6000 8
F 1 7000 4
S 1 400 04
I 0 410 08
C 00
W 410 6000 8
W 400 5400 4
I 1 420 04
C 00
W 420 7000 4

// ==== filelist.f ====
common/hyper_pkg.sv
hdl/lsab_fill.sv
lsab/lsab_buffer.sv
mover/hyper_mvblck_todram.sv
hdl/dram_column_store.sv
hdl/hyper_block_top.sv
tb/tb_hyper_block.sv

// ==== Makefile ====
# Verilator build and run for the block mover testbench.
VERILATOR ?= verilator
TOP       ?= tb_hyper_block
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
